// File: all.f
source/raster_pkg.sv
source/raster_stream_buf.sv
source/raster_ctrl.sv
source/raster_edge_eval.sv
source/raster_dispatch.sv
source/raster_slice.sv
source/raster_quad_merge.sv
source/raster_unit.sv
sim/raster_unit_tb.sv

// File: Bender.yml
package:
  name: raster_unit

sources:
  - source/raster_pkg.sv
  - source/raster_stream_buf.sv
  - source/raster_ctrl.sv
  - source/raster_edge_eval.sv
  - source/raster_dispatch.sv
  - source/raster_slice.sv
  - source/raster_quad_merge.sv
  - source/raster_unit.sv
  - target: test
    files:
      - sim/raster_unit_tb.sv

// File: sim/raster_unit_tb.sv
`timescale 1ns/1ps

module raster_unit_tb;

    localparam int NUM_SLICES     = 2;
    localparam int TILE_LOGSIZE   = 3;
    localparam int TILE_SIZE      = 1 << TILE_LOGSIZE;
    localparam int QUADS_PER_TILE = (TILE_SIZE / 2) * (TILE_SIZE / 2);
    localparam int RAND_BATCHES   = 6;
    localparam int BATCH_TILES    = 4;
    localparam int NUM_TILES      = 2 + RAND_BATCHES * BATCH_TILES;
    localparam int TIMEOUT_NS     = NUM_TILES * (QUADS_PER_TILE + 20) * 4 * 4;

    typedef struct {
        int         xpos;
        int         ypos;
        int         pid;
        logic [3:0] mask;
    } exp_quad_t;

    logic               clk;
    logic               reset;
    logic               in_valid;
    logic               in_ready;
    raster_pkg::coord_t in_xloc;
    raster_pkg::coord_t in_yloc;
    raster_pkg::pid_t   in_pid;
    raster_pkg::edges_t in_edges;
    logic               in_last;
    logic               out_valid;
    raster_pkg::coord_t out_xpos;
    raster_pkg::coord_t out_ypos;
    logic [3:0]         out_mask;
    raster_pkg::pid_t   out_pid;
    logic               out_done;
    logic               out_ready;

    int        seed;
    int        ready_seed;
    logic      throttle;
    int        mismatch_errors;
    int        other_errors;
    int        done_count;
    int        batch_target;
    int        pending_batches;
    int        quads_seen;
    int        quads_expected;
    int        next_pid;
    int        edge_a [3];
    int        edge_b [3];
    int        edge_c [3];
    exp_quad_t exp_q [$];

    raster_unit #(
        .NUM_SLICES   (NUM_SLICES),
        .TILE_LOGSIZE (TILE_LOGSIZE)
    ) raster_unit_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_xloc   (in_xloc),
        .in_yloc   (in_yloc),
        .in_pid    (in_pid),
        .in_edges  (in_edges),
        .in_last   (in_last),
        .out_valid (out_valid),
        .out_xpos  (out_xpos),
        .out_ypos  (out_ypos),
        .out_mask  (out_mask),
        .out_pid   (out_pid),
        .out_done  (out_done),
        .out_ready (out_ready)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s: got %h, expected %h", name, got, expected);
            mismatch_errors++;
        end
    endtask

    // Expected quads of one tile, evaluated at absolute pixel coordinates
    function automatic void expect_tile(input int xloc, input int yloc, input int pid);
        exp_quad_t  q;
        logic [3:0] m;
        int         x;
        int         y;
        for (int qy = 0; qy < TILE_SIZE; qy += 2) begin
            for (int qx = 0; qx < TILE_SIZE; qx += 2) begin
                m = 4'hF;
                for (int p = 0; p < 4; p++) begin
                    x = xloc + qx + (p % 2);
                    y = yloc + qy + (p / 2);
                    for (int e = 0; e < 3; e++) begin
                        if (edge_a[e] * x + edge_b[e] * y + edge_c[e] < 0) begin
                            m[p] = 1'b0;
                        end
                    end
                end
                if (m != 4'h0) begin
                    q.xpos = xloc + qx;
                    q.ypos = yloc + qy;
                    q.pid  = pid;
                    q.mask = m;
                    exp_q.push_back(q);
                    quads_expected++;
                end
            end
        end
    endfunction

    // Each edge passes near a random pixel of the tile, so c stays small
    task automatic random_edges(input int xloc, input int yloc);
        int cx;
        int cy;
        for (int e = 0; e < 3; e++) begin
            edge_a[e] = $random(seed) % 9;
            edge_b[e] = $random(seed) % 9;
            cx = $random(seed) & 7;
            cy = $random(seed) & 7;
            edge_c[e] = -(edge_a[e] * (xloc + cx) + edge_b[e] * (yloc + cy))
                      + $random(seed) % 5;
        end
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_tile(input int xloc, input int yloc, input logic last);
        expect_tile(xloc, yloc, next_pid);
        in_valid = 1'b1;
        in_xloc  = raster_pkg::coord_t'(xloc);
        in_yloc  = raster_pkg::coord_t'(yloc);
        in_pid   = raster_pkg::pid_t'(next_pid);
        in_last  = last;
        for (int e = 0; e < 3; e++) begin
            in_edges[e].a = raster_pkg::data_t'(edge_a[e]);
            in_edges[e].b = raster_pkg::data_t'(edge_b[e]);
            in_edges[e].c = raster_pkg::data_t'(edge_c[e]);
        end
        while (!in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
        next_pid = (next_pid + 1) % 256;
    endtask

    task automatic open_batch(input logic slow_output);
        throttle = slow_output;
        @(negedge clk);
        pending_batches++;
        batch_target   = done_count + 1;
        quads_expected = 0;
        quads_seen     = 0;
    endtask

    task automatic close_batch();
        wait (done_count == batch_target);
        check_value("out_valid beats", quads_seen, quads_expected);
    endtask

    // Own random stream, so the ready pattern is independent of the tiles
    always @(negedge clk) begin
        if (throttle) begin
            out_ready = ($random(ready_seed) & 1) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clk) begin : compare_output
        int match;
        if (!reset && out_valid && out_ready) begin
            if (out_done) begin
                check_value("out_mask", 32'(out_mask), 32'h0);
                if (exp_q.size() != 0) begin
                    $display("done beat arrived while %0d quads were still expected",
                             exp_q.size());
                    other_errors++;
                end
                if (pending_batches == 0) begin
                    $display("done beat arrived with no batch open");
                    other_errors++;
                end else begin
                    pending_batches--;
                end
                done_count++;
            end else begin
                match = -1;
                foreach (exp_q[i]) begin
                    if (match < 0 && exp_q[i].xpos == int'(out_xpos)
                            && exp_q[i].ypos == int'(out_ypos)
                            && exp_q[i].pid == int'(out_pid)) begin
                        match = i;
                    end
                end
                if (match < 0) begin
                    $display("quad at x=%0d y=%0d pid=%0d was not expected",
                             out_xpos, out_ypos, out_pid);
                    other_errors++;
                end else begin
                    check_value("out_mask", 32'(out_mask), 32'(exp_q[match].mask));
                    exp_q.delete(match);
                end
                quads_seen++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns", TIMEOUT_NS);
        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        int xloc;
        int yloc;
        seed            = 32'h5768137b;
        ready_seed      = ~seed;
        clk             = 1'b0;
        reset           = 1'b1;
        in_valid        = 1'b0;
        in_xloc         = '0;
        in_yloc         = '0;
        in_pid          = '0;
        in_edges        = '0;
        in_last         = 1'b0;
        out_ready       = 1'b1;
        throttle        = 1'b0;
        mismatch_errors = 0;
        other_errors    = 0;
        done_count      = 0;
        batch_target    = 0;
        pending_batches = 0;
        quads_seen      = 0;
        quads_expected  = 0;
        next_pid        = 1;

        repeat (8) @(negedge clk);
        reset = 1'b0;
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("in_ready", 32'(in_ready), 32'h1);

        // Tile fully inside all three edges
        open_batch(1'b0);
        edge_a = '{1, 0, -1};
        edge_b = '{0, 1, -1};
        edge_c = '{0, 0, 4000};
        send_tile(64, 32, 1'b1);
        close_batch();
        check_value("out_valid beats", quads_seen, QUADS_PER_TILE);

        // Tile fully outside the first edge
        open_batch(1'b0);
        edge_a = '{2, 0, 0};
        edge_b = '{1, 0, 0};
        edge_c = '{-1000, 1, 1};
        send_tile(200, 120, 1'b1);
        close_batch();
        check_value("out_valid beats", quads_seen, 0);

        // Random partial tiles, second half with a throttled output
        for (int b = 0; b < RAND_BATCHES; b++) begin
            open_batch(b >= RAND_BATCHES / 2);
            for (int t = 0; t < BATCH_TILES; t++) begin
                xloc = ($random(seed) & 255) * TILE_SIZE;
                yloc = ($random(seed) & 255) * TILE_SIZE;
                random_edges(xloc, yloc);
                send_tile(xloc, yloc, t == BATCH_TILES - 1);
            end
            close_batch();
        end

        throttle = 1'b0;
        repeat (20) @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("done beats", done_count, 2 + RAND_BATCHES);

        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: source/raster_unit.sv
`timescale 1ns/1ps

module raster_unit #(
    parameter int NUM_SLICES   = 2,
    parameter int TILE_LOGSIZE = 3
) (
    input  logic               clk,
    input  logic               reset,

    input  logic               in_valid,
    output logic               in_ready,
    input  raster_pkg::coord_t in_xloc,
    input  raster_pkg::coord_t in_yloc,
    input  raster_pkg::pid_t   in_pid,
    input  raster_pkg::edges_t in_edges,
    input  logic               in_last,

    output logic               out_valid,
    output raster_pkg::coord_t out_xpos,
    output raster_pkg::coord_t out_ypos,
    output logic [3:0]         out_mask,
    output raster_pkg::pid_t   out_pid,
    output logic               out_done,
    input  logic               out_ready
);

    raster_pkg::tile_t                  in_tile;
    raster_pkg::tile_t                  eval_tile;
    raster_pkg::tile_t                  slice_tile;
    raster_pkg::quad_t                  out_quad;
    raster_pkg::quad_t [NUM_SLICES-1:0] slice_quad;

    logic                  eval_valid;
    logic                  eval_ready;
    logic                  dispatch_fire;
    logic [NUM_SLICES-1:0] slice_in_valid;
    logic [NUM_SLICES-1:0] slice_in_ready;
    logic [NUM_SLICES-1:0] slice_busy;
    logic [NUM_SLICES-1:0] slice_out_valid;
    logic [NUM_SLICES-1:0] slice_out_ready;
    logic                  done_req;
    logic                  done_ack;

    assign in_tile = '{xloc: in_xloc, yloc: in_yloc, pid: in_pid, edges: in_edges};

    assign out_xpos = out_quad.xpos;
    assign out_ypos = out_quad.ypos;
    assign out_mask = out_quad.mask;
    assign out_pid  = out_quad.pid;
    assign out_done = out_quad.done;

    raster_ctrl #(
        .NUM_SLICES (NUM_SLICES)
    ) ctrl (
        .clk           (clk),
        .reset         (reset),
        .in_fire       (in_valid && in_ready),
        .in_last       (in_last),
        .dispatch_fire (dispatch_fire),
        .slice_busy    (slice_busy),
        .done_req      (done_req),
        .done_ack      (done_ack)
    );

    raster_edge_eval edge_eval (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_tile   (in_tile),
        .out_valid (eval_valid),
        .out_tile  (eval_tile),
        .out_ready (eval_ready)
    );

    raster_dispatch #(
        .NUM_SLICES (NUM_SLICES)
    ) dispatch (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (eval_valid),
        .in_ready    (eval_ready),
        .in_tile     (eval_tile),
        .slice_valid (slice_in_valid),
        .slice_tile  (slice_tile),
        .slice_ready (slice_in_ready),
        .fire        (dispatch_fire)
    );

    for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
        raster_slice #(
            .TILE_LOGSIZE (TILE_LOGSIZE)
        ) slice (
            .clk       (clk),
            .reset     (reset),
            .in_valid  (slice_in_valid[i]),
            .in_tile   (slice_tile),
            .in_ready  (slice_in_ready[i]),
            .busy      (slice_busy[i]),
            .out_valid (slice_out_valid[i]),
            .out_quad  (slice_quad[i]),
            .out_ready (slice_out_ready[i])
        );
    end

    raster_quad_merge #(
        .NUM_SLICES (NUM_SLICES)
    ) quad_merge (
        .clk         (clk),
        .reset       (reset),
        .slice_valid (slice_out_valid),
        .slice_quad  (slice_quad),
        .slice_ready (slice_out_ready),
        .done_req    (done_req),
        .done_ack    (done_ack),
        .out_valid   (out_valid),
        .out_quad    (out_quad),
        .out_ready   (out_ready)
    );

endmodule

// File: source/raster_quad_merge.sv
`timescale 1ns/1ps

module raster_quad_merge #(
    parameter int NUM_SLICES = 2
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [NUM_SLICES-1:0]                slice_valid,
    input  raster_pkg::quad_t [NUM_SLICES-1:0]   slice_quad,
    output logic [NUM_SLICES-1:0]                slice_ready,
    input  logic                                 done_req,
    output logic                                 done_ack,
    output logic                                 out_valid,
    output raster_pkg::quad_t                    out_quad,
    input  logic                                 out_ready
);

    localparam int PTR_BITS = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic [PTR_BITS-1:0] ptr;
    logic [PTR_BITS-1:0] sel;
    logic                found;
    logic                buf_in_valid;
    logic                buf_in_ready;
    raster_pkg::quad_t   buf_in_quad;
    raster_pkg::quad_t   done_quad;

    always_comb begin
        int idx;
        found = 1'b0;
        sel   = ptr;
        for (int i = 0; i < NUM_SLICES; i++) begin
            idx = (int'(ptr) + i) % NUM_SLICES;
            if (!found && slice_valid[idx]) begin
                found = 1'b1;
                sel   = PTR_BITS'(idx);
            end
        end
    end

    assign done_quad = '{xpos: '0, ypos: '0, mask: 4'd0, pid: '0, done: 1'b1};

    // Slice quads win over the done beat
    assign buf_in_valid = found || done_req;
    assign buf_in_quad  = found ? slice_quad[sel] : done_quad;
    assign slice_ready  = (found && buf_in_ready) ? (NUM_SLICES'(1) << sel) : '0;
    assign done_ack     = !found && done_req && buf_in_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (found && buf_in_ready) begin
            ptr <= (int'(sel) == NUM_SLICES - 1) ? '0 : sel + 1'b1;
        end
    end

    raster_stream_buf #(
        .payload_t (raster_pkg::quad_t)
    ) out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (buf_in_valid),
        .in_data   (buf_in_quad),
        .in_ready  (buf_in_ready),
        .out_valid (out_valid),
        .out_data  (out_quad),
        .out_ready (out_ready)
    );

endmodule

// File: source/raster_slice.sv
`timescale 1ns/1ps

module raster_slice #(
    parameter int TILE_LOGSIZE = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    input  raster_pkg::tile_t in_tile,
    output logic              in_ready,
    output logic              busy,
    output logic              out_valid,
    output raster_pkg::quad_t out_quad,
    input  logic              out_ready
);

    // Quad index bits per axis
    localparam int QBITS = TILE_LOGSIZE - 1;

    logic               active;
    raster_pkg::tile_t  tile_r;
    logic [QBITS-1:0]   qx;
    logic [QBITS-1:0]   qy;
    raster_pkg::coord_t dx;
    raster_pkg::coord_t dy;
    logic [3:0]         mask;
    raster_pkg::quad_t  quad;
    logic               buf_in_valid;
    logic               buf_in_ready;
    logic               advance;
    logic               last_quad;

    assign dx = raster_pkg::coord_t'({qx, 1'b0});
    assign dy = raster_pkg::coord_t'({qy, 1'b0});

    // Pixel edge values, taken relative to the tile origin
    always_comb begin
        raster_pkg::data_t v [4];
        mask = 4'hF;
        for (int e = 0; e < 3; e++) begin
            v[0] = tile_r.edges[e].a * raster_pkg::data_t'(dx)
                 + tile_r.edges[e].b * raster_pkg::data_t'(dy)
                 + tile_r.edges[e].c;
            v[1] = v[0] + tile_r.edges[e].a;
            v[2] = v[0] + tile_r.edges[e].b;
            v[3] = v[1] + tile_r.edges[e].b;
            for (int p = 0; p < 4; p++) begin
                if (v[p][raster_pkg::DATA_BITS-1]) begin
                    mask[p] = 1'b0;
                end
            end
        end
    end

    assign quad.xpos = tile_r.xloc + dx;
    assign quad.ypos = tile_r.yloc + dy;
    assign quad.mask = mask;
    assign quad.pid  = tile_r.pid;
    assign quad.done = 1'b0;

    // Empty quads are skipped, a full buffer pauses the walk
    assign buf_in_valid = active && (mask != 4'd0);
    assign advance      = active && ((mask == 4'd0) || buf_in_ready);
    assign last_quad    = (&qx) && (&qy);

    assign busy     = active || out_valid;
    assign in_ready = !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            qx     <= '0;
            qy     <= '0;
        end else if (in_valid && in_ready) begin
            active <= 1'b1;
            qx     <= '0;
            qy     <= '0;
        end else if (advance) begin
            qx <= qx + 1'b1;
            if (&qx) begin
                qy <= qy + 1'b1;
            end
            if (last_quad) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            tile_r <= in_tile;
        end
    end

    raster_stream_buf #(
        .payload_t (raster_pkg::quad_t)
    ) out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (buf_in_valid),
        .in_data   (quad),
        .in_ready  (buf_in_ready),
        .out_valid (out_valid),
        .out_data  (out_quad),
        .out_ready (out_ready)
    );

    // Nothing empty ever leaves the slice
    assert property (@(posedge clk) disable iff (reset) out_valid |-> (out_quad.mask != 4'd0));

endmodule

// File: source/raster_dispatch.sv
`timescale 1ns/1ps

module raster_dispatch #(
    parameter int NUM_SLICES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  raster_pkg::tile_t     in_tile,
    output logic [NUM_SLICES-1:0] slice_valid,
    output raster_pkg::tile_t     slice_tile,
    input  logic [NUM_SLICES-1:0] slice_ready,
    output logic                  fire
);

    localparam int PTR_BITS = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic [PTR_BITS-1:0] ptr;
    logic [PTR_BITS-1:0] sel;
    logic                found;

    // First idle slice at or after the pointer
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = ptr;
        for (int i = 0; i < NUM_SLICES; i++) begin
            idx = (int'(ptr) + i) % NUM_SLICES;
            if (!found && slice_ready[idx]) begin
                found = 1'b1;
                sel   = PTR_BITS'(idx);
            end
        end
    end

    assign in_ready    = found;
    assign fire        = in_valid && found;
    assign slice_tile  = in_tile;
    assign slice_valid = fire ? (NUM_SLICES'(1) << sel) : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (fire) begin
            ptr <= (int'(sel) == NUM_SLICES - 1) ? '0 : sel + 1'b1;
        end
    end

endmodule

// File: source/raster_edge_eval.sv
`timescale 1ns/1ps

module raster_edge_eval (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  raster_pkg::tile_t  in_tile,
    output logic               out_valid,
    output raster_pkg::tile_t  out_tile,
    input  logic               out_ready
);

    logic              stall;
    logic              s1_valid;
    logic              s2_valid;
    raster_pkg::tile_t s1_tile;
    raster_pkg::tile_t s2_tile;
    raster_pkg::data_t ax [3];
    raster_pkg::data_t by [3];

    // Whole pipeline holds while the last stage waits on the dispatcher
    assign stall     = s2_valid && !out_ready;
    assign in_ready  = !stall;
    assign out_valid = s2_valid;
    assign out_tile  = s2_tile;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            // Stage 1 forms the origin products
            s1_tile <= in_tile;
            for (int e = 0; e < 3; e++) begin
                ax[e] <= in_tile.edges[e].a * raster_pkg::data_t'(in_tile.xloc);
                by[e] <= in_tile.edges[e].b * raster_pkg::data_t'(in_tile.yloc);
            end
            // Stage 2 folds them into c
            s2_tile <= s1_tile;
            for (int e = 0; e < 3; e++) begin
                s2_tile.edges[e].c <= ax[e] + by[e] + s1_tile.edges[e].c;
            end
        end
    end

endmodule

// File: source/raster_ctrl.sv
`timescale 1ns/1ps

module raster_ctrl #(
    parameter int NUM_SLICES = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_fire,
    input  logic                  in_last,
    input  logic                  dispatch_fire,
    input  logic [NUM_SLICES-1:0] slice_busy,
    output logic                  done_req,
    input  logic                  done_ack
);

    // Tiles between the input port and a slice
    localparam int CNT_BITS = $clog2(raster_pkg::EDGE_LATENCY + 2);

    logic [CNT_BITS-1:0] cnt;
    logic                batch_end;
    logic                armed;
    logic                drained;

    assign drained = (cnt == '0) && !(|slice_busy);

    // Once raised, the request holds until the merger takes it
    assign done_req = batch_end && (drained || armed);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt       <= '0;
            batch_end <= 1'b0;
            armed     <= 1'b0;
        end else begin
            cnt <= cnt + CNT_BITS'(in_fire) - CNT_BITS'(dispatch_fire);
            if (in_fire && in_last) begin
                batch_end <= 1'b1;
            end else if (done_ack) begin
                batch_end <= 1'b0;
            end
            if (done_ack) begin
                armed <= 1'b0;
            end else if (done_req) begin
                armed <= 1'b1;
            end
        end
    end

    // A handoff to a slice needs a tile that came in earlier
    assert property (@(posedge clk) disable iff (reset) dispatch_fire |-> (cnt != '0));

endmodule

// File: source/raster_stream_buf.sv
`timescale 1ns/1ps

module raster_stream_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    payload_t   entries [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_data;
        end
    end

    // Equal pointers only when empty or full, so no push lands on an unread entry
    assert property (@(posedge clk) disable iff (reset)
        (wr_ptr == rd_ptr) == ((count == 2'd0) || (count == 2'd2)));

endmodule

// File: source/raster_pkg.sv
package raster_pkg;

    // Pixel coordinate and primitive id widths
    localparam int DIM_BITS  = 11;
    localparam int PID_BITS  = 8;

    // Edge arithmetic wraps around at this width
    localparam int DATA_BITS = 24;

    // Registered stages in the edge evaluator
    localparam int EDGE_LATENCY = 2;

    typedef logic [DIM_BITS-1:0] coord_t;
    typedef logic [PID_BITS-1:0] pid_t;
    typedef logic signed [DATA_BITS-1:0] data_t;

    // Value at pixel (x, y) is a*x + b*y + c
    typedef struct packed {
        data_t a;
        data_t b;
        data_t c;
    } edge_t;

    typedef edge_t [2:0] edges_t;

    // Origin is the top-left pixel of the tile
    typedef struct packed {
        coord_t xloc;
        coord_t yloc;
        pid_t   pid;
        edges_t edges;
    } tile_t;

    // Mask bits: (x,y), (x+1,y), (x,y+1), (x+1,y+1)
    typedef struct packed {
        coord_t     xpos;
        coord_t     ypos;
        logic [3:0] mask;
        pid_t       pid;
        logic       done;
    } quad_t;

endpackage
